//--- src.f
rv_rf_pkg.sv
gpr_file.sv
wb_format.sv
store_unit.sv
rf_subsys.sv
rf_subsys_assertions.sv
tb_rf_subsys.sv

//--- Bender.yml
package:
  name: rf_subsys

dependencies: {}

sources:
  # package first, then the blocks, then the top level
  - rv_rf_pkg.sv
  - gpr_file.sv
  - wb_format.sv
  - store_unit.sv
  - rf_subsys.sv

  # testbench and bound checker
  - target: test
    files:
      - rf_subsys_assertions.sv
      - tb_rf_subsys.sv

//--- tb_rf_subsys.sv
`timescale 1ns/100ps

module tb_rf_subsys;

    localparam int n_random   = 400;
    localparam int n_directed = 40;            // reset reads, preloads, directed stores
    localparam int clk_period = 20;
    localparam int margin_cyc = 200;

    logic                       clk;
    logic                       rst_n;
    rv_rf_pkg::rf_cmd_t         cmd;
    logic [rv_rf_pkg::xlen-1:0] rs1_data;
    logic [rv_rf_pkg::xlen-1:0] rs2_data;
    rv_rf_pkg::mem_req_t        mem_req;
    logic                       misalign;

    logic [rv_rf_pkg::xlen-1:0] model [rv_rf_pkg::reg_count];   // write history
    int                         err_cnt;
    int                         seed;

    rf_subsys dut0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .cmd      (cmd),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .mem_req  (mem_req),
        .misalign (misalign)
    );

    initial clk = 1'b0;

    always #(clk_period / 2) clk = ~clk;

    // register value expected after a write of the given kind
    function automatic logic [rv_rf_pkg::xlen-1:0] expect_write(
        input rv_rf_pkg::wb_kind_e       kind,
        input logic [rv_rf_pkg::xlen-1:0] raw
    );
        logic [rv_rf_pkg::xlen-1:0] val;
        case (kind)
            rv_rf_pkg::wb_word_sext: val = {{32{raw[31]}}, raw[31:0]};
            rv_rf_pkg::wb_word_zext: val = {32'h0, raw[31:0]};
            default:                 val = raw;
        endcase
        return val;
    endfunction

    function automatic rv_rf_pkg::rf_cmd_t read_cmd(input logic [4:0] ra, input logic [4:0] rb);
        rv_rf_pkg::rf_cmd_t c;
        c     = '0;                             // valid low so only the reads act
        c.rs1 = ra;
        c.rs2 = rb;
        return c;
    endfunction

    function automatic rv_rf_pkg::rf_cmd_t write_cmd(
        input logic [4:0]                 rd,
        input logic [rv_rf_pkg::xlen-1:0] result,
        input rv_rf_pkg::wb_kind_e        kind
    );
        rv_rf_pkg::rf_cmd_t c;
        c         = '0;
        c.valid   = 1'b1;
        c.rd      = rd;
        c.rs1     = rd;                         // old value of rd on the read port
        c.result  = result;
        c.wb_kind = kind;
        return c;
    endfunction

    function automatic rv_rf_pkg::rf_cmd_t store_cmd(
        input logic [4:0]          base_reg,
        input logic [4:0]          data_reg,
        input rv_rf_pkg::st_size_e size,
        input logic [31:0]         imm
    );
        rv_rf_pkg::rf_cmd_t c;
        c          = '0;
        c.valid    = 1'b1;
        c.is_store = 1'b1;
        c.rd       = data_reg;                  // a store must leave rd alone
        c.rs1      = base_reg;
        c.rs2      = data_reg;
        c.st_size  = size;
        c.imm      = imm;
        return c;
    endfunction

    task automatic check_read(
        input string                      name,
        input logic [rv_rf_pkg::xlen-1:0] exp,
        input logic [rv_rf_pkg::xlen-1:0] act
    );
        if (act !== exp) begin
            err_cnt++;
            $display("Mismatch at time %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    // drive on the falling edge and check the settled reads
    task automatic send(input rv_rf_pkg::rf_cmd_t c);
        @(negedge clk);
        cmd = c;
        #1;
        check_read("rs1_data", model[c.rs1], rs1_data);
        check_read("rs2_data", model[c.rs2], rs2_data);
        if (c.valid && !c.is_store && (c.rd != '0)) begin
            model[c.rd] = expect_write(c.wb_kind, c.result);
        end
    endtask

    initial begin
        #((n_directed + n_random) * clk_period + margin_cyc * clk_period);
        $display("timeout: the test did not finish in the expected time");
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        logic [31:0] r;
        logic [31:0] hi;
        logic [31:0] lo;
        logic [31:0] imm;
        int          fails;
        err_cnt = 0;
        seed    = 32'h38a2;
        rst_n   = 1'b0;
        cmd     = '0;
        for (int i = 0; i < rv_rf_pkg::reg_count; i++) begin
            model[i] = '0;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // every register reads zero out of reset
        for (int i = 0; i < rv_rf_pkg::reg_count; i += 2) begin
            send(read_cmd(5'(i), 5'(i + 1)));
        end

        // preload registers and try a write to x0
        send(write_cmd(5'd0, 64'hdead_beef_cafe_f00d, rv_rf_pkg::wb_dword));
        send(write_cmd(5'd5, 64'h0123_4567_89ab_cdef, rv_rf_pkg::wb_dword));
        send(write_cmd(5'd6, 64'h5555_0000_8000_1234, rv_rf_pkg::wb_word_sext));
        send(write_cmd(5'd7, 64'hffff_0000_9abc_def0, rv_rf_pkg::wb_word_zext));
        send(write_cmd(5'd8, 64'h0000_0000_0000_1000, rv_rf_pkg::wb_dword));
        send(write_cmd(5'd9, 64'h1122_3344_5566_7788, rv_rf_pkg::wb_dword));

        // directed aligned and refused stores
        send(store_cmd(5'd8, 5'd9, rv_rf_pkg::st_dword, 32'd0));
        send(store_cmd(5'd8, 5'd9, rv_rf_pkg::st_word, 32'd4));
        send(store_cmd(5'd8, 5'd9, rv_rf_pkg::st_half, 32'd3));          // odd address
        send(store_cmd(5'd8, 5'd9, rv_rf_pkg::st_byte, 32'hffff_ffff));  // lane 7
        send(store_cmd(5'd8, 5'd9, rv_rf_pkg::st_dword, 32'hffff_fffc)); // lane 4
        send(store_cmd(5'd0, 5'd9, rv_rf_pkg::st_word, 32'd8));          // x0 base
        send(store_cmd(5'd5, 5'd6, rv_rf_pkg::st_half, 32'd1));
        send(read_cmd(5'd7, 5'd0));

        for (int i = 0; i < n_random; i++) begin
            r   = $random(seed);
            hi  = $random(seed);
            lo  = $random(seed);
            imm = {{24{r[23]}}, r[23:16]};      // -128 .. 127
            if (r[2:0] < 3'd3) begin
                send(store_cmd(r[8:4], r[13:9], rv_rf_pkg::st_size_e'(r[15:14]), imm));
            end else begin
                send(write_cmd(r[8:4], {hi, lo}, rv_rf_pkg::wb_kind_e'(r[25:24] % 2'd3)));
            end
        end

        send('0);                               // let the last store pulse out
        send('0);
        @(negedge clk);

        fails = dut0.chk0.fail_cnt;
        $display("errors: %0d read mismatches, %0d assertion failures", err_cnt, fails);
        if ((err_cnt == 0) && (fails == 0)) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- rf_subsys_assertions.sv
`timescale 1ns/100ps

module rf_subsys_checker (
    input logic                       clk,
    input logic                       rst_n,
    input rv_rf_pkg::rf_cmd_t         cmd,
    input logic [rv_rf_pkg::xlen-1:0] rs1_data,
    input logic [rv_rf_pkg::xlen-1:0] rs2_data,
    input rv_rf_pkg::mem_req_t        mem_req,
    input logic                       misalign
);

    logic [rv_rf_pkg::xlen-1:0] shadow [rv_rf_pkg::reg_count];
    int                         fail_cnt = 0;

    logic [rv_rf_pkg::xlen-1:0] base_val;
    logic [rv_rf_pkg::xlen-1:0] data_val;
    logic [rv_rf_pkg::xlen-1:0] exp_addr;
    logic [rv_rf_pkg::xlen-1:0] exp_wdata;
    logic [rv_rf_pkg::xlen-1:0] exp_bits;      // mask widened to bits
    logic [7:0]                 exp_mask;
    logic [3:0]                 size_bytes;
    logic                       exp_aligned;
    logic                       store_go;

    logic                       wen_q;
    logic                       mis_q;
    logic [rv_rf_pkg::xlen-1:0] addr_q;
    logic [rv_rf_pkg::xlen-1:0] wdata_q;
    logic [rv_rf_pkg::xlen-1:0] bits_q;
    logic [7:0]                 mask_q;

    function automatic logic [rv_rf_pkg::xlen-1:0] read_shadow(input logic [4:0] idx);
        logic [rv_rf_pkg::xlen-1:0] val;
        val = (idx == '0) ? '0 : shadow[idx];
        return val;
    endfunction

    function automatic logic [rv_rf_pkg::xlen-1:0] shape_value(
        input rv_rf_pkg::wb_kind_e        kind,
        input logic [rv_rf_pkg::xlen-1:0] raw
    );
        logic [rv_rf_pkg::xlen-1:0] val;
        case (kind)
            rv_rf_pkg::wb_word_sext: val = {{32{raw[31]}}, raw[31:0]};
            rv_rf_pkg::wb_word_zext: val = {32'h0, raw[31:0]};
            default:                 val = raw;
        endcase
        return val;
    endfunction

    assign store_go = cmd.valid && cmd.is_store;

    always_comb begin
        base_val  = read_shadow(cmd.rs1);
        data_val  = read_shadow(cmd.rs2);
        exp_addr  = base_val + {{32{cmd.imm[31]}}, cmd.imm};
        case (cmd.st_size)
            rv_rf_pkg::st_byte: size_bytes = 4'd1;
            rv_rf_pkg::st_half: size_bytes = 4'd2;
            rv_rf_pkg::st_word: size_bytes = 4'd4;
            default:            size_bytes = 4'd8;
        endcase
        exp_aligned = ((exp_addr[2:0] & 3'(size_bytes - 4'd1)) == 3'b000);
        exp_mask    = 8'(((16'd1 << size_bytes) - 16'd1) << exp_addr[2:0]);
        exp_wdata   = data_val << {exp_addr[2:0], 3'b000};
        for (int i = 0; i < 8; i++) begin
            exp_bits[8*i +: 8] = {8{exp_mask[i]}};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < rv_rf_pkg::reg_count; i++) begin
                shadow[i] <= '0;
            end
            wen_q   <= 1'b0;
            mis_q   <= 1'b0;
            addr_q  <= '0;
            wdata_q <= '0;
            bits_q  <= '0;
            mask_q  <= '0;
        end else begin
            if (cmd.valid && !cmd.is_store && (cmd.rd != '0)) begin
                shadow[cmd.rd] <= shape_value(cmd.wb_kind, cmd.result);
            end
            wen_q   <= store_go && exp_aligned;
            mis_q   <= store_go && !exp_aligned;
            addr_q  <= exp_addr;
            wdata_q <= exp_wdata;
            bits_q  <= exp_bits;
            mask_q  <= exp_mask;
        end
    end

    a_reset_quiet: assert property (@(posedge clk) !rst_n |-> (!mem_req.wen && !misalign))
        else begin
            $error("memory write or misalign active during reset");
            fail_cnt++;
        end

    a_x0_rs1: assert property (@(posedge clk) disable iff (!rst_n)
        (cmd.rs1 == '0) |-> (rs1_data == '0))
        else begin
            $error("rs1_data nonzero on a read of x0");
            fail_cnt++;
        end

    a_x0_rs2: assert property (@(posedge clk) disable iff (!rst_n)
        (cmd.rs2 == '0) |-> (rs2_data == '0))
        else begin
            $error("rs2_data nonzero on a read of x0");
            fail_cnt++;
        end

    a_rs1_value: assert property (@(posedge clk) disable iff (!rst_n) rs1_data == base_val)
        else begin
            $error("rs1_data differs from the register history");
            fail_cnt++;
        end

    a_rs2_value: assert property (@(posedge clk) disable iff (!rst_n) rs2_data == data_val)
        else begin
            $error("rs2_data differs from the register history");
            fail_cnt++;
        end

    a_wen_pulse: assert property (@(posedge clk) disable iff (!rst_n) mem_req.wen == wen_q)
        else begin
            $error("memory write pulse wrong for the store sampled");
            fail_cnt++;
        end

    a_misalign_pulse: assert property (@(posedge clk) disable iff (!rst_n) misalign == mis_q)
        else begin
            $error("misalign pulse wrong for the store sampled");
            fail_cnt++;
        end

    a_store_addr: assert property (@(posedge clk) disable iff (!rst_n)
        wen_q |-> ((mem_req.addr == addr_q) && (mem_req.wmask == mask_q)))
        else begin
            $error("store address or byte mask wrong");
            fail_cnt++;
        end

    a_store_data: assert property (@(posedge clk) disable iff (!rst_n)
        wen_q |-> ((mem_req.wdata & bits_q) == (wdata_q & bits_q)))
        else begin
            $error("store data wrong in the written lanes");
            fail_cnt++;
        end

endmodule

bind rf_subsys rf_subsys_checker chk0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd      (cmd),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .mem_req  (mem_req),
    .misalign (misalign)
);

//--- rf_subsys.sv
`timescale 1ns/100ps

module rf_subsys (
    input  logic                       clk,
    input  logic                       rst_n,

    input  rv_rf_pkg::rf_cmd_t         cmd,       // one command per cycle

    output logic [rv_rf_pkg::xlen-1:0] rs1_data,
    output logic [rv_rf_pkg::xlen-1:0] rs2_data,

    output rv_rf_pkg::mem_req_t        mem_req,   // registered store write
    output logic                       misalign
);

    rv_rf_pkg::rf_write_t wr;                     // formatted register write

    // combinational result to register value
    wb_format u_wb_format (
        .cmd (cmd),
        .wr  (wr)
    );

    // register array read straight from the command indices
    gpr_file u_gpr_file (
        .clk    (clk),
        .rst_n  (rst_n),
        .wr     (wr),
        .raddr1 (cmd.rs1),
        .raddr2 (cmd.rs2),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    // store path works beside wb_format on the same command
    store_unit u_store_unit (
        .clk      (clk),
        .rst_n    (rst_n),
        .cmd      (cmd),
        .base     (rs1_data),                     // base register value
        .data     (rs2_data),                     // store data register value
        .mem_req  (mem_req),
        .misalign (misalign)
    );

endmodule

//--- store_unit.sv
`timescale 1ns/100ps

module store_unit (
    input  logic                       clk,
    input  logic                       rst_n,

    input  rv_rf_pkg::rf_cmd_t         cmd,
    input  logic [rv_rf_pkg::xlen-1:0] base,      // rs1 read value
    input  logic [rv_rf_pkg::xlen-1:0] data,      // rs2 read value

    output rv_rf_pkg::mem_req_t        mem_req,
    output logic                       misalign   // one-cycle pulse for a refused store
);

    logic [rv_rf_pkg::xlen-1:0]       imm_ext;
    logic [rv_rf_pkg::xlen-1:0]       st_addr;
    logic [rv_rf_pkg::lane_w-1:0]     lane;       // first lane written
    logic [rv_rf_pkg::byte_lanes-1:0] size_mask;  // mask before the lane shift
    logic [rv_rf_pkg::byte_lanes-1:0] st_mask;
    logic                             aligned;
    logic                             store_go;   // store sampled this edge
    rv_rf_pkg::rf_word_u              data_in;
    rv_rf_pkg::rf_word_u              data_out;

    assign store_go = cmd.valid && cmd.is_store;

    // effective address
    assign imm_ext = {{(rv_rf_pkg::xlen - rv_rf_pkg::imm_w){cmd.imm[rv_rf_pkg::imm_w-1]}},
                      cmd.imm};
    assign st_addr = base + imm_ext;
    assign lane    = st_addr[rv_rf_pkg::lane_w-1:0];

    // natural alignment and lane count per size
    always_comb begin
        case (cmd.st_size)
            rv_rf_pkg::st_byte: begin
                size_mask = 8'h01;
                aligned   = 1'b1;                 // bytes always fit
            end
            rv_rf_pkg::st_half: begin
                size_mask = 8'h03;
                aligned   = (lane[0] == 1'b0);
            end
            rv_rf_pkg::st_word: begin
                size_mask = 8'h0f;
                aligned   = (lane[1:0] == 2'b00);
            end
            default: begin
                size_mask = 8'hff;                // st_dword
                aligned   = (lane == '0);
            end
        endcase
    end

    assign st_mask = size_mask << lane;

    // move the low bytes of rs2 up to the addressed lane
    assign data_in.dword = data;

    always_comb begin
        data_out.dword = '0;
        for (int i = 0; i < rv_rf_pkg::byte_lanes; i++) begin
            if (i >= int'(lane)) begin
                data_out.bytes[i] = data_in.bytes[i - int'(lane)];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_req  <= '0;
            misalign <= 1'b0;
        end else begin
            mem_req.wen <= store_go && aligned;   // single pulse per store
            misalign    <= store_go && !aligned;
            if (store_go && aligned) begin
                mem_req.addr  <= st_addr;
                mem_req.wdata <= data_out.dword;
                mem_req.wmask <= st_mask;
            end
        end
    end

endmodule

//--- wb_format.sv
`timescale 1ns/100ps

module wb_format (
    input  rv_rf_pkg::rf_cmd_t   cmd,
    output rv_rf_pkg::rf_write_t wr
);

    rv_rf_pkg::rf_word_u         res;        // raw result in lane view
    logic [rv_rf_pkg::word_w-1:0] low_word;
    logic                        low_sign;   // bit 31 of the result
    logic [rv_rf_pkg::xlen-1:0]  sext_val;
    logic [rv_rf_pkg::xlen-1:0]  zext_val;

    assign res.dword = cmd.result;

    // low word is the bottom four lanes
    assign low_word = res.bytes[rv_rf_pkg::word_lanes-1:0];
    assign low_sign = low_word[rv_rf_pkg::word_w-1];

    assign sext_val = {{(rv_rf_pkg::xlen - rv_rf_pkg::word_w){low_sign}}, low_word};
    assign zext_val = {{(rv_rf_pkg::xlen - rv_rf_pkg::word_w){1'b0}}, low_word};

    // stores never write a register
    assign wr.wen   = cmd.valid && !cmd.is_store;
    assign wr.waddr = cmd.rd;

    always_comb begin
        case (cmd.wb_kind)
            rv_rf_pkg::wb_dword:     wr.wdata = res.dword;
            rv_rf_pkg::wb_word_sext: wr.wdata = sext_val;   // *w ops
            rv_rf_pkg::wb_word_zext: wr.wdata = zext_val;
            default:                 wr.wdata = res.dword;  // unused code passes through
        endcase
    end

endmodule

//--- gpr_file.sv
`timescale 1ns/100ps

module gpr_file (
    input  logic                             clk,
    input  logic                             rst_n,

    input  rv_rf_pkg::rf_write_t             wr,      // from writeback formatting

    input  logic [rv_rf_pkg::reg_addr_w-1:0] raddr1,  // store base index
    input  logic [rv_rf_pkg::reg_addr_w-1:0] raddr2,  // store data index
    output logic [rv_rf_pkg::xlen-1:0]       rdata1,
    output logic [rv_rf_pkg::xlen-1:0]       rdata2
);

    logic [rv_rf_pkg::xlen-1:0] regs [rv_rf_pkg::reg_count];
    logic                       wr_ok;                // write allowed this cycle

    // writes to x0 are dropped here
    assign wr_ok = wr.wen && (wr.waddr != '0);

    // read mux used by both ports
    function automatic logic [rv_rf_pkg::xlen-1:0] read_reg(
        input logic [rv_rf_pkg::reg_addr_w-1:0] idx
    );
        logic [rv_rf_pkg::xlen-1:0] val;
        if (idx == '0) begin
            val = '0;                                 // x0 hardwired
        end else begin
            val = regs[idx];
        end
        return val;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < rv_rf_pkg::reg_count; i++) begin
                regs[i] <= '0;                        // every register reads zero
            end
        end else if (wr_ok) begin
            regs[wr.waddr] <= wr.wdata;
        end
    end

    // combinational reads see the value before this cycle's write
    always_comb begin
        rdata1 = read_reg(raddr1);
    end

    always_comb begin
        rdata2 = read_reg(raddr2);
    end

endmodule

//--- rv_rf_pkg.sv
package rv_rf_pkg;

    localparam int xlen       = 64;            // integer register width
    localparam int reg_addr_w = 5;             // x0..x31
    localparam int reg_count  = 32;
    localparam int word_w     = 32;            // low word for the *w forms
    localparam int imm_w      = 32;            // store immediate as delivered
    localparam int byte_lanes = xlen / 8;      // lanes in one doubleword
    localparam int lane_w     = 3;             // lane index bits, log2 of byte_lanes
    localparam int word_lanes = word_w / 8;    // lanes covered by the low word

    // register write format
    typedef enum logic [1:0] {
        wb_dword     = 2'd0,                   // whole result
        wb_word_sext = 2'd1,                   // addw, subw, sllw ...
        wb_word_zext = 2'd2                    // unsigned word results
    } wb_kind_e;

    // store width encoded as log2 of the byte count
    typedef enum logic [1:0] {
        st_byte  = 2'd0,                       // sb
        st_half  = 2'd1,                       // sh
        st_word  = 2'd2,                       // sw
        st_dword = 2'd3                        // sd
    } st_size_e;

    // one register word seen whole or lane by lane
    typedef union packed {
        logic [xlen-1:0]            dword;
        logic [byte_lanes-1:0][7:0] bytes;     // bytes[0] is the lowest lane
    } rf_word_u;

    // one write or store command per cycle
    typedef struct packed {
        logic                    valid;
        logic                    is_store;     // high for a store, low for a write
        logic [reg_addr_w-1:0]   rd;           // write target
        logic [reg_addr_w-1:0]   rs1;          // store base register
        logic [reg_addr_w-1:0]   rs2;          // store data register
        logic [xlen-1:0]         result;       // raw result before formatting
        wb_kind_e                wb_kind;
        st_size_e                st_size;
        logic signed [imm_w-1:0] imm;          // store offset
    } rf_cmd_t;

    // registered memory write port
    typedef struct packed {
        logic                  wen;            // one-cycle pulse
        logic [xlen-1:0]       addr;           // byte address that need not be lane aligned
        logic [xlen-1:0]       wdata;          // already shifted into its lanes
        logic [byte_lanes-1:0] wmask;          // one bit per lane written
    } mem_req_t;

    // register file write port
    typedef struct packed {
        logic                  wen;
        logic [reg_addr_w-1:0] waddr;
        logic [xlen-1:0]       wdata;          // formatted value
    } rf_write_t;

endpackage
